/* fetch_fifo.sv */
/*
 * fetch FIFO
 * circular buffer of fetched words, each tagged with its address and a bus error flag
 */

`timescale 1ns/1ps

module fetch_fifo #(
  parameter int unsigned FifoDepth = 2
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           flush_i,
  input  logic                           push_i,
  input  fetch_pkg::instr_t              push_rdata_i,
  input  fetch_pkg::addr_t               push_addr_i,
  input  logic                           push_err_i,
  input  logic                           pop_i,
  output logic                           valid_o,
  output fetch_pkg::instr_t              rdata_o,
  output fetch_pkg::addr_t               addr_o,
  output logic                           err_o,
  output logic [$clog2(FifoDepth+1)-1:0] count_o
);

  localparam int unsigned PtrW = $clog2(FifoDepth);
  localparam int unsigned CntW = $clog2(FifoDepth + 1);

  fetch_pkg::instr_t rdata_q [FifoDepth];
  fetch_pkg::addr_t  addr_q  [FifoDepth];
  logic              err_q   [FifoDepth];

  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            full;
  logic            do_push, do_pop;

  assign full    = (count_q == CntW'(FifoDepth));
  assign valid_o = (count_q != '0);
  // a full FIFO still takes a word when the head leaves in the same cycle
  assign do_pop  = pop_i & valid_o;
  assign do_push = push_i & (~full | do_pop);

  // head entry straight from storage
  assign rdata_o = rdata_q[rd_ptr_q];
  assign addr_o  = addr_q[rd_ptr_q];
  assign err_o   = err_q[rd_ptr_q];
  assign count_o = count_q;

  // pointers and occupancy
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        // explicit wrap for depths that are not a power of two
        wr_ptr_q <= (wr_ptr_q == PtrW'(FifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(FifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CntW'(do_push) - CntW'(do_pop);
    end
  end

  // entry storage
  always_ff @(posedge clk_i) begin
    if (do_push && !flush_i) begin
      rdata_q[wr_ptr_q] <= push_rdata_i;
      addr_q[wr_ptr_q]  <= push_addr_i;
      err_q[wr_ptr_q]   <= push_err_i;
    end
  end

endmodule

/* fetch_if_id_reg.sv */
/*
 * IF-ID pipeline register
 * takes the FIFO head when ID is ready, holds valid and new flags, squashed by a PC set
 */

`timescale 1ns/1ps

module fetch_if_id_reg (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              pc_set_i,
  input  logic              id_in_ready_i,
  input  logic              instr_valid_clear_i,
  input  logic              fetch_valid_i,
  input  fetch_pkg::instr_t fetch_rdata_i,
  input  fetch_pkg::addr_t  fetch_addr_i,
  input  logic              fetch_err_i,
  input  logic              pmp_err_if_i,
  output logic              fetch_pop_o,
  output logic              instr_valid_id_o,
  output logic              instr_new_id_o,
  output fetch_pkg::instr_t instr_rdata_id_o,
  output logic              instr_fetch_err_o,
  output fetch_pkg::addr_t  pc_id_o
);

  logic accept;
  logic valid_d;

  // no capture in the PC set cycle, the head belongs to the old stream
  assign accept      = fetch_valid_i & id_in_ready_i & ~pc_set_i;
  assign fetch_pop_o = accept;

  // held until cleared by ID, dropped by a redirect
  assign valid_d = accept | (instr_valid_id_o & ~instr_valid_clear_i & ~pc_set_i);

  ////////////////////
  // flags
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_id_o <= 1'b0;
      instr_new_id_o   <= 1'b0;
    end else begin
      instr_valid_id_o <= valid_d;
      // one-cycle pulse per capture
      instr_new_id_o   <= accept;
    end
  end

  ////////////////////
  // payload
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_rdata_id_o  <= '0;
      instr_fetch_err_o <= 1'b0;
      pc_id_o           <= '0;
    end else if (accept) begin
      instr_rdata_id_o  <= fetch_rdata_i;
      // bus error of the word or PMP fault on its address
      instr_fetch_err_o <= fetch_err_i | pmp_err_if_i;
      pc_id_o           <= fetch_addr_i;
    end
  end

endmodule

/* fetch_pc_sel.sv */
/*
 * next-PC selection
 * computes the exception vector and picks the PC target on a PC set
 */

`timescale 1ns/1ps

module fetch_pc_sel #(
  parameter fetch_pkg::addr_t DmHaltAddr      = 32'h1A11_0800,
  parameter fetch_pkg::addr_t DmExceptionAddr = 32'h1A11_0808
) (
  input  logic                           pc_set_i,
  input  fetch_pkg::pc_sel_e             pc_mux_i,
  input  fetch_pkg::exc_pc_sel_e         exc_pc_mux_i,
  input  logic                           exc_irq_i,
  input  logic                           exc_irq_int_i,
  input  logic [fetch_pkg::IrqIdW-1:0]   exc_irq_id_i,
  input  fetch_pkg::addr_t               boot_addr_i,
  input  fetch_pkg::addr_t               branch_target_ex_i,
  input  fetch_pkg::addr_t               csr_mepc_i,
  input  fetch_pkg::addr_t               csr_depc_i,
  input  fetch_pkg::addr_t               csr_mtvec_i,
  output fetch_pkg::addr_t               pc_set_target_o,
  output logic                           csr_mtvec_init_o
);

  logic [fetch_pkg::IrqIdW-1:0] irq_id;
  logic [fetch_pkg::IrqIdW+1:0] irq_off;
  fetch_pkg::addr_t             exc_base;
  fetch_pkg::addr_t             exc_pc;
  fetch_pkg::addr_t             next_pc;

  ////////////////////
  // exception vector
  ////////////////////

  // internal interrupts all share the nmi slot
  assign irq_id   = exc_irq_int_i ? fetch_pkg::NmiIrqId : exc_irq_id_i;
  // word offset into the vector table, none for a plain exception
  assign irq_off  = exc_irq_i ? {irq_id, 2'b00} : '0;
  assign exc_base = {csr_mtvec_i[31:fetch_pkg::VecBaseLsb], {fetch_pkg::VecBaseLsb{1'b0}}};

  always_comb begin
    unique case (exc_pc_mux_i)
      fetch_pkg::EXC_PC_EXC:     exc_pc = exc_base;
      fetch_pkg::EXC_PC_IRQ:     exc_pc = exc_base + fetch_pkg::addr_t'(irq_off);
      fetch_pkg::EXC_PC_DBD:     exc_pc = DmHaltAddr;
      fetch_pkg::EXC_PC_DBG_EXC: exc_pc = DmExceptionAddr;
      default:                   exc_pc = exc_base;
    endcase
  end

  ////////////////////
  // next PC mux
  ////////////////////

  always_comb begin
    unique case (pc_mux_i)
      fetch_pkg::PC_BOOT: next_pc = boot_addr_i;
      fetch_pkg::PC_JUMP: next_pc = branch_target_ex_i;
      fetch_pkg::PC_EXC:  next_pc = exc_pc;
      // return from trap
      fetch_pkg::PC_ERET: next_pc = csr_mepc_i;
      // return from debug mode
      fetch_pkg::PC_DRET: next_pc = csr_depc_i;
      default:            next_pc = boot_addr_i;
    endcase
  end

  // halfword bit is never set on a target
  assign pc_set_target_o  = {next_pc[31:1], 1'b0};
  // CSR file loads mtvec from boot address on a boot set
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == fetch_pkg::PC_BOOT);

endmodule

/* fetch_pkg.sv */
/*
 * fetch stage package
 * shared address and instruction types, PC-select encodings and exception vector constants
 */

package fetch_pkg;

  // one word of address or instruction
  typedef logic [31:0] addr_t;
  typedef logic [31:0] instr_t;

  // next-PC source selected on a PC set
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // exception target kind
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  // interrupt id width and the id shared by all internal interrupts
  parameter int unsigned IrqIdW = 5;
  parameter logic [IrqIdW-1:0] NmiIrqId = 5'd31;

  // mtvec base starts at this bit, the bits below are replaced
  parameter int unsigned VecBaseLsb = 8;

endpackage

/* fetch_prefetch.sv */
/*
 * prefetch unit
 * drives the instruction bus one transaction at a time, drops responses of a stale
 * stream after a branch and fills the fetch FIFO
 */

`timescale 1ns/1ps

module fetch_prefetch #(
  parameter int unsigned FifoDepth = 2
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_i,
  input  logic              branch_i,
  input  fetch_pkg::addr_t  branch_addr_i,
  input  logic              pop_i,
  input  logic              instr_gnt_i,
  input  logic              instr_rvalid_i,
  input  fetch_pkg::instr_t instr_rdata_i,
  input  logic              instr_bus_err_i,
  output logic              instr_req_o,
  output fetch_pkg::addr_t  instr_addr_o,
  output logic              valid_o,
  output fetch_pkg::instr_t rdata_o,
  output fetch_pkg::addr_t  addr_o,
  output logic              err_o,
  output logic              busy_o
);

  localparam int unsigned CntW = $clog2(FifoDepth + 1);

  fetch_pkg::addr_t fetch_addr_q, fetch_addr_d;
  fetch_pkg::addr_t req_addr_q;
  logic             hold_q, outstanding_q, discard_q;
  logic             discard_d;
  logic             inflight, space_ok, new_req, granted, resp_done, push;
  logic [CntW-1:0]  fifo_count;

  ////////////////////
  // request side
  ////////////////////

  // request waiting for grant or response waiting for rvalid
  assign inflight = hold_q | outstanding_q;
  // entries plus the transaction in flight must stay below the depth
  assign space_ok = (int'(fifo_count) + int'(inflight)) < int'(FifoDepth);
  // never in the branch cycle, the target request starts one cycle later
  assign new_req  = req_i & ~branch_i & ~inflight & space_ok;

  // a waiting request keeps its address until granted
  assign instr_req_o  = hold_q | new_req;
  assign instr_addr_o = hold_q ? req_addr_q : fetch_addr_q;
  assign granted      = instr_req_o & instr_gnt_i;
  assign resp_done    = outstanding_q & instr_rvalid_i;

  always_comb begin
    fetch_addr_d = fetch_addr_q;
    if (branch_i) begin
      fetch_addr_d = {branch_addr_i[31:2], 2'b00};
    end else if (granted && !discard_q) begin
      // sequential stream, one word per grant
      fetch_addr_d = fetch_addr_q + 32'd4;
    end
  end

  // stale transaction across a branch
  always_comb begin
    discard_d = discard_q;
    if (branch_i && (hold_q || (outstanding_q && !instr_rvalid_i))) begin
      discard_d = 1'b1;
    end else if (resp_done) begin
      discard_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_addr_q  <= '0;
      hold_q        <= 1'b0;
      outstanding_q <= 1'b0;
      discard_q     <= 1'b0;
    end else begin
      fetch_addr_q  <= fetch_addr_d;
      hold_q        <= instr_req_o & ~instr_gnt_i;
      outstanding_q <= granted | (outstanding_q & ~instr_rvalid_i);
      discard_q     <= discard_d;
    end
  end

  // address of the current transaction, reused as the FIFO tag
  always_ff @(posedge clk_i) begin
    if (instr_req_o) begin
      req_addr_q <= instr_addr_o;
    end
  end

  ////////////////////
  // response side
  ////////////////////

  // response of the old stream is dropped, also when it lands in the branch cycle
  assign push   = resp_done & ~discard_q & ~branch_i;
  assign busy_o = inflight;

  fetch_fifo #(
    .FifoDepth (FifoDepth)
  ) i_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (branch_i),
    .push_i       (push),
    .push_rdata_i (instr_rdata_i),
    .push_addr_i  (req_addr_q),
    .push_err_i   (instr_bus_err_i),
    .pop_i        (pop_i),
    .valid_o      (valid_o),
    .rdata_o      (rdata_o),
    .addr_o       (addr_o),
    .err_o        (err_o),
    .count_o      (fifo_count)
  );

endmodule

/* fetch_stage_top.sv */
/*
 * instruction fetch stage
 * next-PC selection, prefetch with fetch FIFO and the IF-ID register
 */

`timescale 1ns/1ps

module fetch_stage_top #(
  parameter fetch_pkg::addr_t DmHaltAddr      = 32'h1A11_0800,
  parameter fetch_pkg::addr_t DmExceptionAddr = 32'h1A11_0808,
  parameter int unsigned      FifoDepth       = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         req_i,
  // instruction bus
  output logic                         instr_req_o,
  output fetch_pkg::addr_t             instr_addr_o,
  input  logic                         instr_gnt_i,
  input  logic                         instr_rvalid_i,
  input  fetch_pkg::instr_t            instr_rdata_i,
  input  logic                         instr_bus_err_i,
  // PC control
  input  logic                         pc_set_i,
  input  fetch_pkg::pc_sel_e           pc_mux_i,
  input  fetch_pkg::exc_pc_sel_e       exc_pc_mux_i,
  input  logic                         exc_irq_i,
  input  logic                         exc_irq_int_i,
  input  logic [fetch_pkg::IrqIdW-1:0] exc_irq_id_i,
  input  fetch_pkg::addr_t             boot_addr_i,
  input  fetch_pkg::addr_t             branch_target_ex_i,
  input  fetch_pkg::addr_t             csr_mepc_i,
  input  fetch_pkg::addr_t             csr_depc_i,
  input  fetch_pkg::addr_t             csr_mtvec_i,
  // pipeline control
  input  logic                         id_in_ready_i,
  input  logic                         instr_valid_clear_i,
  input  logic                         pmp_err_if_i,
  output fetch_pkg::addr_t             pc_set_target_o,
  output logic                         csr_mtvec_init_o,
  output logic                         instr_valid_id_o,
  output logic                         instr_new_id_o,
  output fetch_pkg::instr_t            instr_rdata_id_o,
  output logic                         instr_fetch_err_o,
  output fetch_pkg::addr_t             pc_if_o,
  output fetch_pkg::addr_t             pc_id_o,
  output logic                         if_busy_o
);

  fetch_pkg::addr_t  branch_addr;
  logic              fetch_valid;
  fetch_pkg::instr_t fetch_rdata;
  fetch_pkg::addr_t  fetch_addr;
  logic              fetch_err;
  logic              fetch_pop;

  fetch_pc_sel #(
    .DmHaltAddr      (DmHaltAddr),
    .DmExceptionAddr (DmExceptionAddr)
  ) i_pc_sel (
    .pc_set_i           (pc_set_i),
    .pc_mux_i           (pc_mux_i),
    .exc_pc_mux_i       (exc_pc_mux_i),
    .exc_irq_i          (exc_irq_i),
    .exc_irq_int_i      (exc_irq_int_i),
    .exc_irq_id_i       (exc_irq_id_i),
    .boot_addr_i        (boot_addr_i),
    .branch_target_ex_i (branch_target_ex_i),
    .csr_mepc_i         (csr_mepc_i),
    .csr_depc_i         (csr_depc_i),
    .csr_mtvec_i        (csr_mtvec_i),
    .pc_set_target_o    (branch_addr),
    .csr_mtvec_init_o   (csr_mtvec_init_o)
  );

  assign pc_set_target_o = branch_addr;

  // PC set redirects the prefetcher in the same cycle
  fetch_prefetch #(
    .FifoDepth (FifoDepth)
  ) i_prefetch (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .branch_i        (pc_set_i),
    .branch_addr_i   (branch_addr),
    .pop_i           (fetch_pop),
    .instr_gnt_i     (instr_gnt_i),
    .instr_rvalid_i  (instr_rvalid_i),
    .instr_rdata_i   (instr_rdata_i),
    .instr_bus_err_i (instr_bus_err_i),
    .instr_req_o     (instr_req_o),
    .instr_addr_o    (instr_addr_o),
    .valid_o         (fetch_valid),
    .rdata_o         (fetch_rdata),
    .addr_o          (fetch_addr),
    .err_o           (fetch_err),
    .busy_o          (if_busy_o)
  );

  // IF PC is the address of the FIFO head
  assign pc_if_o = fetch_addr;

  fetch_if_id_reg i_if_id_reg (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .pc_set_i            (pc_set_i),
    .id_in_ready_i       (id_in_ready_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .fetch_valid_i       (fetch_valid),
    .fetch_rdata_i       (fetch_rdata),
    .fetch_addr_i        (fetch_addr),
    .fetch_err_i         (fetch_err),
    .pmp_err_if_i        (pmp_err_if_i),
    .fetch_pop_o         (fetch_pop),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o),
    .pc_id_o             (pc_id_o)
  );

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the fetch stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch_stage -f src.f
output=$(./obj_dir/Vtb_fetch_stage)
echo "$output"

if grep -qF "*** TEST PASSED ***" <<< "$output"; then
  exit 0
fi
exit 1

/* src.f */
fetch_pkg.sv
fetch_pc_sel.sv
fetch_fifo.sv
fetch_prefetch.sv
fetch_if_id_reg.sv
fetch_stage_top.sv
tb_fetch_stage_props.sv
tb_fetch_stage.sv

/* tb_fetch_stage.sv */
/*
 * fetch stage testbench
 * random PC sets, bus timing and ID back-pressure checked against a reference model
 */

`timescale 1ns/1ps

module tb_fetch_stage;

  localparam logic [31:0] DmHaltAddr      = 32'h1A11_0800;
  localparam logic [31:0] DmExceptionAddr = 32'h1A11_0808;
  localparam int          FifoDepth       = 3;
  localparam int          PhaseCycles     = 600;
  localparam int          NumPhases       = 4;
  // all phases, drain and reset with margin
  localparam int          TimeoutCycles   = (NumPhases + 1) * PhaseCycles + 1000;

  logic clk = 1'b0;
  logic rst_n;

  // DUT inputs
  logic                         req;
  logic                         instr_gnt;
  logic                         instr_rvalid;
  logic [31:0]                  instr_rdata;
  logic                         instr_bus_err;
  logic                         pc_set;
  fetch_pkg::pc_sel_e           pc_mux;
  fetch_pkg::exc_pc_sel_e       exc_pc_mux;
  logic                         exc_irq;
  logic                         exc_irq_int;
  logic [fetch_pkg::IrqIdW-1:0] exc_irq_id;
  logic [31:0]                  boot_addr;
  logic [31:0]                  branch_target;
  logic [31:0]                  csr_mepc;
  logic [31:0]                  csr_depc;
  logic [31:0]                  csr_mtvec;
  logic                         id_in_ready;
  logic                         instr_valid_clear;
  logic                         pmp_err_if;

  // DUT outputs
  logic        instr_req;
  logic [31:0] instr_addr;
  logic [31:0] pc_set_target;
  logic        csr_mtvec_init;
  logic        instr_valid_id;
  logic        instr_new_id;
  logic [31:0] instr_rdata_id;
  logic        instr_fetch_err;
  logic [31:0] pc_if;
  logic [31:0] pc_id;
  logic        if_busy;

  integer seed      = 32'h9cba;
  int     errors    = 0;
  int     cycles    = 0;
  int     delivered = 0;

  // reference model state for the next PC, FIFO occupancy and ID flags
  logic [31:0] exp_pc;
  bit          exp_new;
  bit          exp_valid;
  bit          pmp_prev;
  int          occ;
  // stream number bumped on every PC set
  int          epoch;
  // bus model response countdown and the stream that issued the request
  int          resp_wait;
  logic [31:0] resp_addr;
  int          resp_epoch;
  int          req_epoch;
  bit          req_waiting;
  // phase knobs
  bit          boot_next;
  bit          req_on;
  bit          backpressure;
  bit          pmp_on;
  int unsigned set_mask;

  fetch_stage_top #(
    .DmHaltAddr      (DmHaltAddr),
    .DmExceptionAddr (DmExceptionAddr),
    .FifoDepth       (FifoDepth)
  ) i_dut (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .req_i               (req),
    .instr_req_o         (instr_req),
    .instr_addr_o        (instr_addr),
    .instr_gnt_i         (instr_gnt),
    .instr_rvalid_i      (instr_rvalid),
    .instr_rdata_i       (instr_rdata),
    .instr_bus_err_i     (instr_bus_err),
    .pc_set_i            (pc_set),
    .pc_mux_i            (pc_mux),
    .exc_pc_mux_i        (exc_pc_mux),
    .exc_irq_i           (exc_irq),
    .exc_irq_int_i       (exc_irq_int),
    .exc_irq_id_i        (exc_irq_id),
    .boot_addr_i         (boot_addr),
    .branch_target_ex_i  (branch_target),
    .csr_mepc_i          (csr_mepc),
    .csr_depc_i          (csr_depc),
    .csr_mtvec_i         (csr_mtvec),
    .id_in_ready_i       (id_in_ready),
    .instr_valid_clear_i (instr_valid_clear),
    .pmp_err_if_i        (pmp_err_if),
    .pc_set_target_o     (pc_set_target),
    .csr_mtvec_init_o    (csr_mtvec_init),
    .instr_valid_id_o    (instr_valid_id),
    .instr_new_id_o      (instr_new_id),
    .instr_rdata_id_o    (instr_rdata_id),
    .instr_fetch_err_o   (instr_fetch_err),
    .pc_if_o             (pc_if),
    .pc_id_o             (pc_id),
    .if_busy_o           (if_busy)
  );

  bind fetch_stage_top tb_fetch_stage_props i_props (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .instr_req_i      (instr_req_o),
    .instr_addr_i     (instr_addr_o),
    .instr_gnt_i      (instr_gnt_i),
    .instr_valid_id_i (instr_valid_id_o)
  );

  always #4 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("run did not finish within %0d cycles, %0d errors so far", cycles, errors);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  ////////////////////
  // model functions
  ////////////////////

  // memory contents seen on the bus
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return addr ^ 32'hA5A5_0000;
  endfunction

  // one faulty word in every 64-byte block
  function automatic bit bus_err_at(input logic [31:0] addr);
    return addr[5:2] == 4'hF;
  endfunction

  // true with a chance of one in mask+1
  function automatic bit rand_hit(input int unsigned mask);
    return ($unsigned($random(seed)) & mask) == 0;
  endfunction

  function automatic logic [31:0] model_target();
    logic [31:0] base;
    logic [31:0] vec;
    logic [31:0] pc;
    logic [4:0]  id;
    // mtvec base keeps bits 31:8
    base = {csr_mtvec[31:8], 8'h00};
    // internal interrupts use id 31
    id   = exc_irq_int ? 5'd31 : exc_irq_id;
    case (exc_pc_mux)
      fetch_pkg::EXC_PC_EXC: vec = base;
      fetch_pkg::EXC_PC_IRQ: vec = exc_irq ? base + {25'd0, id, 2'b00} : base;
      fetch_pkg::EXC_PC_DBD: vec = DmHaltAddr;
      default:               vec = DmExceptionAddr;
    endcase
    case (pc_mux)
      fetch_pkg::PC_BOOT: pc = boot_addr;
      fetch_pkg::PC_JUMP: pc = branch_target;
      fetch_pkg::PC_EXC:  pc = vec;
      fetch_pkg::PC_ERET: pc = csr_mepc;
      default:            pc = csr_depc;
    endcase
    return {pc[31:1], 1'b0};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at time %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  task automatic drive_inputs();
    logic [31:0] r;
    logic [31:0] sel;
    r   = $random(seed);
    sel = $unsigned($random(seed)) % 32'd5;
    req = req_on;
    pc_set = boot_next | (set_mask != 0 && rand_hit(set_mask));
    pc_mux = boot_next ? fetch_pkg::PC_BOOT : fetch_pkg::pc_sel_e'(sel[2:0]);
    boot_next = 1'b0;
    exc_pc_mux = fetch_pkg::exc_pc_sel_e'(r[1:0]);
    exc_irq = r[2];
    exc_irq_int = r[3];
    exc_irq_id = r[8:4];
    boot_addr = $random(seed);
    branch_target = $random(seed);
    csr_mepc = $random(seed);
    csr_depc = $random(seed);
    csr_mtvec = $random(seed);
    // ID stalls half the time under back-pressure
    id_in_ready = !(backpressure && rand_hit(1));
    instr_valid_clear = rand_hit(3);
    pmp_err_if = pmp_on && rand_hit(3);
    instr_gnt = rand_hit(1);
    // response 1 to 3 cycles after the grant
    instr_rvalid = 1'b0;
    instr_bus_err = 1'b0;
    instr_rdata = $random(seed);
    if (resp_wait > 0) begin
      resp_wait = resp_wait - 1;
      if (resp_wait == 0) begin
        instr_rvalid = 1'b1;
        instr_rdata = mem_word(resp_addr);
        instr_bus_err = bus_err_at(resp_addr);
      end
    end
  endtask

  // outputs are settled at the falling edge
  task automatic check_cycle();
    bit          set_now;
    bit          push;
    bit          cap;
    bit          resp_due;
    int          pending;
    logic [31:0] tgt;
    set_now = pc_set;
    tgt = model_target();
    if (set_now) begin
      check_value("pc_set_target_o", pc_set_target, tgt);
    end
    check_value("csr_mtvec_init_o", 32'(csr_mtvec_init),
                32'(set_now && pc_mux == fetch_pkg::PC_BOOT));
    check_value("instr_new_id_o", 32'(instr_new_id), 32'(exp_new));
    check_value("instr_valid_id_o", 32'(instr_valid_id), 32'(exp_valid));
    if (instr_new_id && exp_new) begin
      check_value("pc_id_o", pc_id, exp_pc);
      check_value("instr_rdata_id_o", instr_rdata_id, mem_word(exp_pc));
      check_value("instr_fetch_err_o", 32'(instr_fetch_err),
                  32'(bus_err_at(exp_pc) | pmp_prev));
      exp_pc = exp_pc + 32'd4;
      delivered++;
    end
    // head of the FIFO is the next PC to deliver
    if (occ > 0) begin
      check_value("pc_if_o", pc_if, exp_pc);
    end
    // FIFO entries plus the word on the bus
    resp_due = resp_wait != 0 || instr_rvalid;
    pending = occ + (resp_due ? 1 : 0);
    // busy while a request waits for its grant or a response is due
    check_value("if_busy_o", 32'(if_busy), 32'(req_waiting || resp_due));
    if (instr_req && pending >= FifoDepth) begin
      errors++;
      $display("at time %0t a request was issued with %0d words pending", $time, pending);
    end
    // a new request belongs to the stream current when it first rises
    if (instr_req && !req_waiting) begin
      req_epoch = epoch;
    end
    push = instr_rvalid && !set_now && resp_epoch == epoch;
    if (instr_req && instr_gnt) begin
      if (resp_due) begin
        errors++;
        $display("at time %0t a grant was taken while a response was still due", $time);
      end
      resp_wait  = 1 + int'($unsigned($random(seed)) % 32'd3);
      resp_addr  = instr_addr;
      resp_epoch = req_epoch;
    end
    req_waiting = instr_req && !instr_gnt;
    if (set_now) begin
      epoch++;
    end
    // no capture into ID in a PC set cycle
    cap = occ > 0 && id_in_ready && !set_now;
    occ = set_now ? 0 : occ + int'(push) - int'(cap);
    exp_valid = cap || (exp_valid && !instr_valid_clear && !set_now);
    exp_new = cap;
    pmp_prev = pmp_err_if;
    if (set_now) begin
      exp_pc = {tgt[31:2], 2'b00};
    end
  endtask

  task automatic step();
    @(posedge clk);
    #1;
    drive_inputs();
    @(negedge clk);
    check_cycle();
  endtask

  task automatic run_phase(input int n, input bit bp, input int unsigned smask,
                           input bit pmp);
    req_on = 1'b1;
    backpressure = bp;
    set_mask = smask;
    pmp_on = pmp;
    repeat (n) step();
  endtask

  // stop fetching and wait until the stage is idle
  task automatic drain_pipeline();
    req_on = 1'b0;
    backpressure = 1'b0;
    set_mask = 0;
    pmp_on = 1'b0;
    step();
    while (if_busy || occ != 0 || exp_new) begin
      step();
    end
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    rst_n = 1'b1;
    req = 1'b0;
    instr_gnt = 1'b0;
    instr_rvalid = 1'b0;
    instr_rdata = '0;
    instr_bus_err = 1'b0;
    pc_set = 1'b0;
    pc_mux = fetch_pkg::PC_BOOT;
    exc_pc_mux = fetch_pkg::EXC_PC_EXC;
    exc_irq = 1'b0;
    exc_irq_int = 1'b0;
    exc_irq_id = '0;
    boot_addr = '0;
    branch_target = '0;
    csr_mepc = '0;
    csr_depc = '0;
    csr_mtvec = '0;
    id_in_ready = 1'b0;
    instr_valid_clear = 1'b0;
    pmp_err_if = 1'b0;
    exp_pc = '0;
    exp_new = 1'b0;
    exp_valid = 1'b0;
    pmp_prev = 1'b0;
    occ = 0;
    epoch = 0;
    resp_wait = 0;
    resp_addr = '0;
    resp_epoch = 0;
    req_epoch = 0;
    req_waiting = 1'b0;
    boot_next = 1'b1;
    req_on = 1'b0;
    backpressure = 1'b0;
    pmp_on = 1'b0;
    set_mask = 0;
    #2;
    rst_n = 1'b0;
    repeat (7) @(posedge clk);
    @(negedge clk);
    check_value("instr_req_o", 32'(instr_req), 32'd0);
    check_value("instr_valid_id_o", 32'(instr_valid_id), 32'd0);
    check_value("instr_new_id_o", 32'(instr_new_id), 32'd0);
    check_value("if_busy_o", 32'(if_busy), 32'd0);
    check_value("csr_mtvec_init_o", 32'(csr_mtvec_init), 32'd0);
    @(posedge clk);
    #1;
    rst_n = 1'b1;
    // sequential fetch, back-pressure, frequent redirects, PMP faults
    run_phase(PhaseCycles, 1'b0, 63, 1'b0);
    run_phase(PhaseCycles, 1'b1, 63, 1'b0);
    run_phase(PhaseCycles, 1'b1, 7, 1'b0);
    run_phase(PhaseCycles, 1'b1, 31, 1'b1);
    drain_pipeline();
    $display("%0d instructions delivered, %0d errors", delivered, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* tb_fetch_stage_props.sv */
/*
 * fetch stage bus and pipeline properties, bound into the top level
 */

`timescale 1ns/1ps

module tb_fetch_stage_props (
  input logic        clk_i,
  input logic        rst_ni,
  input logic        instr_req_i,
  input logic [31:0] instr_addr_i,
  input logic        instr_gnt_i,
  input logic        instr_valid_id_i
);

  // request waiting for its grant keeps the address
  addr_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_i && !instr_gnt_i |=> instr_req_i && $stable(instr_addr_i))
    else $error("instr_addr_o changed while the request waited for its grant");

  // bus only sees whole words
  addr_aligned_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_i |-> instr_addr_i[1:0] == 2'b00)
    else $error("instr_addr_o is not word-aligned");

  // nothing reaches ID during reset
  reset_valid_a: assert property (@(posedge clk_i) !rst_ni |-> !instr_valid_id_i)
    else $error("instr_valid_id_o is high during reset");

endmodule
